//--- Makefile
# Verilator build and run for the fetch testbench
# variables can be overridden on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_thor_fetch
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j $(JOBS)

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- rtl/icache_ctrl.sv
// icache control, tag and valid store, hit check over line and line+1
// and the miss sequencer that fills a line four words at a time
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl #(
  parameter  int line_count = 64,
  localparam int idx_bits   = $clog2(line_count),
  localparam int la_bits    = thor_fetch_pkg::abw - thor_fetch_pkg::off_bits,
  localparam int tag_bits   = la_bits - idx_bits
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 fetch_req,
  input  logic [thor_fetch_pkg::abw-1:0]       pc,
  output logic                                 fetch_valid,
  output logic                                 fill_req,
  output logic [thor_fetch_pkg::abw-1:0]       fill_addr,
  input  logic                                 fill_ready,
  input  logic                                 fill_rvalid,
  input  logic [thor_fetch_pkg::word_bits-1:0] fill_rdata,
  output logic                                 wce,
  output logic                                 wr,
  output logic [thor_fetch_pkg::abw-1:0]       wa,
  output logic [thor_fetch_pkg::word_bits-1:0] wd
);

  localparam int ob = thor_fetch_pkg::off_bits;
  localparam int ws = thor_fetch_pkg::wsel_bits;

  typedef enum logic {st_idle, st_fill} state_t;

  state_t                state;
  logic [line_count-1:0] valid_q;                 // one per line
  logic [tag_bits-1:0]   tags [line_count];       // upper line address bits
  logic [la_bits-1:0]    line0;                   // line address of pc
  logic [la_bits-1:0]    line1;                   // next line, tag carries on wrap
  logic                  hit0;
  logic                  hit1;
  logic [la_bits-1:0]    fill_line;               // line being filled
  logic [ws:0]           issue_cnt;               // word reads accepted, 0..4
  logic [ws-1:0]         recv_cnt;                // words written back

  assign line0 = pc[thor_fetch_pkg::abw-1:ob];
  assign line1 = line0 + la_bits'(1);

  assign hit0 = valid_q[line0[idx_bits-1:0]] &&
                (tags[line0[idx_bits-1:0]] == line0[la_bits-1:idx_bits]);
  assign hit1 = valid_q[line1[idx_bits-1:0]] &&
                (tags[line1[idx_bits-1:0]] == line1[la_bits-1:idx_bits]);

  // ==========================================================
  // fill port and cache write side
  // ==========================================================
  assign fill_req  = (state == st_fill) && !issue_cnt[ws];           // until four accepted
  assign fill_addr = {fill_line, issue_cnt[ws-1:0], 2'b00};          // held while not ready
  assign wce       = fill_rvalid;                                    // one word per response
  assign wr        = (state == st_fill);
  assign wa        = {fill_line, recv_cnt, 2'b00};
  assign wd        = fill_rdata;

  // ==========================================================
  // sequencer
  // ==========================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= st_idle;
      valid_q     <= '0;
      issue_cnt   <= '0;
      recv_cnt    <= '0;
      fetch_valid <= 1'b0;
    end else begin
      fetch_valid <= 1'b0;
      case (state)
        st_idle: begin
          if (fetch_req && hit0 && hit1) begin
            fetch_valid <= 1'b1;                  // banks read pc this cycle
          end else if (fetch_req) begin
            state     <= st_fill;                 // line at pc goes first
            issue_cnt <= '0;
            recv_cnt  <= '0;
          end
        end
        st_fill: begin
          if (fill_req && fill_ready) begin
            issue_cnt <= issue_cnt + 1'b1;
          end
          if (fill_rvalid) begin
            recv_cnt <= recv_cnt + 1'b1;
            if (recv_cnt == ws'(thor_fetch_pkg::words_per_line - 1)) begin
              valid_q[fill_line[idx_bits-1:0]] <= 1'b1;
              state                            <= st_idle;  // recheck since line+1 may miss
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // fill line choice and tag write
  always_ff @(posedge clk) begin
    if (state == st_idle && fetch_req) begin
      fill_line <= hit0 ? line1 : line0;
    end
    if (state == st_fill && fill_rvalid &&
        recv_cnt == ws'(thor_fetch_pkg::words_per_line - 1)) begin
      tags[fill_line[idx_bits-1:0]] <= fill_line[la_bits-1:idx_bits];
    end
  end

endmodule

`default_nettype wire

//--- rtl/icache_mem.sv
// icache data store, two banks reading the line at pc and the line after it
// plus the byte aligning mux that builds the 128-bit fetch window
`timescale 1ns/1ps
`default_nettype none

module icache_mem #(
  parameter  int line_count = 64,
  localparam int idx_bits   = $clog2(line_count)
) (
  input  logic                                 wclk,
  input  logic                                 wce,
  input  logic                                 wr,
  input  logic [thor_fetch_pkg::abw-1:0]       wa,    // byte address of the fill word
  input  logic [thor_fetch_pkg::word_bits-1:0] wd,
  input  logic                                 rclk,
  input  logic [thor_fetch_pkg::abw-1:0]       pc,
  output logic [thor_fetch_pkg::insn_bits-1:0] insn
);

  localparam int ob = thor_fetch_pkg::off_bits;
  localparam int ws = thor_fetch_pkg::wsel_bits;
  localparam int lb = thor_fetch_pkg::line_bits;

  logic [idx_bits-1:0]    ra0;       // line at pc
  logic [idx_bits-1:0]    ra1;       // following line
  logic [lb-1:0]          line0_q;
  logic [lb-1:0]          line1_q;
  logic [ob-1:0]          off_q;     // pc offset registered with the read
  logic [2*lb-1:0]        pair;      // line+1 above line with byte 0 at the bottom

  assign ra0 = pc[idx_bits+ob-1:ob];
  assign ra1 = ra0 + idx_bits'(1);   // wraps from the last index to 0

  // ==========================================================
  // both banks get every fill word
  // ==========================================================
  icache_ram #(.line_count(line_count)) u_bank0 (
    .wclk (wclk),
    .wce  (wce),
    .wr   (wr),
    .wa   (wa[idx_bits+ob-1:ob-ws]),
    .d    (wd),
    .rclk (rclk),
    .rce  (1'b1),
    .ra   (ra0),
    .q    (line0_q)
  );

  icache_ram #(.line_count(line_count)) u_bank1 (
    .wclk (wclk),
    .wce  (wce),
    .wr   (wr),
    .wa   (wa[idx_bits+ob-1:ob-ws]),
    .d    (wd),
    .rclk (rclk),
    .rce  (1'b1),
    .ra   (ra1),
    .q    (line1_q)
  );

  always_ff @(posedge rclk) begin
    off_q <= pc[ob-1:0];             // lines up with the bank outputs
  end

  // ==========================================================
  // window mux
  // ==========================================================
  // byte k of insn is byte off_q+k of the 32-byte pair
  assign pair = {line1_q, line0_q};
  assign insn = pair[{off_q, 3'b000} +: thor_fetch_pkg::insn_bits];

endmodule

`default_nettype wire

//--- rtl/icache_ram.sv
// one cache bank, simple dual port
// word wide write port and a registered full line read port
`timescale 1ns/1ps
`default_nettype none

module icache_ram #(
  parameter  int line_count = 64,
  localparam int idx_bits   = $clog2(line_count),
  localparam int wa_bits    = idx_bits + thor_fetch_pkg::wsel_bits
) (
  input  logic                                 wclk,
  input  logic                                 wce,  // write port enable
  input  logic                                 wr,   // write strobe
  input  logic [wa_bits-1:0]                   wa,   // word index, line then slot
  input  logic [thor_fetch_pkg::word_bits-1:0] d,
  input  logic                                 rclk,
  input  logic                                 rce,  // read enable
  input  logic [idx_bits-1:0]                  ra,   // line index
  output logic [thor_fetch_pkg::line_bits-1:0] q
);

  localparam int ws = thor_fetch_pkg::wsel_bits;
  localparam int wb = thor_fetch_pkg::word_bits;

  logic [thor_fetch_pkg::line_bits-1:0] lines [line_count];  // one entry per cache line

  // word slot 0 sits in the low bits so the line stays little endian
  always_ff @(posedge wclk) begin
    if (wce && wr) begin
      lines[wa[wa_bits-1:ws]][wa[ws-1:0]*wb +: wb] <= d;
    end
  end

  // whole line out one clock after the address
  always_ff @(posedge rclk) begin
    if (rce) begin
      q <= lines[ra];
    end
  end

endmodule

`default_nettype wire

//--- rtl/main_mem.sv
// backing word memory with a request FIFO, one dequeue per two cycles
// credit pulse on every dequeue and tagged read responses
`timescale 1ns/1ps
`default_nettype none

module main_mem #(
  parameter  int mem_words       = 1024,
  parameter  int mem_queue_depth = 4,
  localparam int maw = $clog2(mem_words),
  localparam int qaw = (mem_queue_depth > 1) ? $clog2(mem_queue_depth) : 1,
  localparam int qcw = $clog2(mem_queue_depth + 1)
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 mem_req,
  input  logic                                 mem_we,
  input  logic [thor_fetch_pkg::abw-1:0]       mem_addr,
  input  logic [thor_fetch_pkg::word_bits-1:0] mem_wdata,
  input  thor_fetch_pkg::src_t                 mem_src,
  output logic                                 mem_credit,
  output logic                                 mem_rvalid,
  output logic [thor_fetch_pkg::word_bits-1:0] mem_rdata,
  output thor_fetch_pkg::src_t                 mem_rsrc
);

  logic [thor_fetch_pkg::word_bits-1:0] mem [mem_words];
  logic                                 q_we    [mem_queue_depth];
  logic [maw-1:0]                       q_addr  [mem_queue_depth];  // word index
  logic [thor_fetch_pkg::word_bits-1:0] q_wdata [mem_queue_depth];
  thor_fetch_pkg::src_t                 q_src   [mem_queue_depth];
  logic [qaw-1:0]                       wr_ptr;
  logic [qaw-1:0]                       rd_ptr;
  logic [qcw-1:0]                       count;
  logic                                 cool;     // dead cycle after a dequeue
  logic                                 deq;
  logic                                 rd_pend;  // read in flight after dequeue
  logic [maw-1:0]                       rd_addr;
  thor_fetch_pkg::src_t                 rd_src;

  assign deq        = (count != '0) && !cool;
  assign mem_credit = deq;                        // slot freed this cycle

  // ==========================================================
  // queue payload and read pipe
  // ==========================================================
  always_ff @(posedge clk) begin
    if (mem_req) begin
      q_we[wr_ptr]    <= mem_we;
      q_addr[wr_ptr]  <= mem_addr[maw+1:2];
      q_wdata[wr_ptr] <= mem_wdata;
      q_src[wr_ptr]   <= mem_src;
    end
    if (deq) begin
      rd_addr <= q_addr[rd_ptr];
      rd_src  <= q_src[rd_ptr];
    end
    mem_rdata <= mem[rd_addr];                    // valid with mem_rvalid
    mem_rsrc  <= rd_src;
  end

  // ==========================================================
  // control and array
  // ==========================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      cool       <= 1'b0;
      rd_pend    <= 1'b0;
      mem_rvalid <= 1'b0;
      for (int i = 0; i < mem_words; i++) begin
        mem[i] <= '0;                             // memory starts cleared
      end
    end else begin
      if (mem_req) begin
        wr_ptr <= (wr_ptr == qaw'(mem_queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (deq) begin
        rd_ptr <= (rd_ptr == qaw'(mem_queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({mem_req, deq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      cool       <= deq;
      rd_pend    <= deq && !q_we[rd_ptr];
      mem_rvalid <= rd_pend;                      // two cycles after dequeue
      if (deq && q_we[rd_ptr]) begin
        mem[q_addr[rd_ptr]] <= q_wdata[rd_ptr];
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/mem_arbiter.sv
// round robin arbiter for the fill and data ports in front of main_mem
// credit counter for the request queue and response routing by source id
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter #(
  parameter  int mem_queue_depth = 4,
  localparam int ccw             = $clog2(mem_queue_depth + 1)
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 fill_req,
  input  logic [thor_fetch_pkg::abw-1:0]       fill_addr,
  output logic                                 fill_ready,
  output logic                                 fill_rvalid,
  output logic [thor_fetch_pkg::word_bits-1:0] fill_rdata,
  input  logic                                 dport_req,
  input  logic                                 dport_we,
  input  logic [thor_fetch_pkg::abw-1:0]       dport_addr,
  input  logic [thor_fetch_pkg::word_bits-1:0] dport_wdata,
  output logic                                 dport_ready,
  output logic                                 dport_rvalid,
  output logic [thor_fetch_pkg::word_bits-1:0] dport_rdata,
  output logic                                 mem_req,
  output logic                                 mem_we,
  output logic [thor_fetch_pkg::abw-1:0]       mem_addr,
  output logic [thor_fetch_pkg::word_bits-1:0] mem_wdata,
  output thor_fetch_pkg::src_t                 mem_src,
  input  logic                                 mem_credit,
  input  logic                                 mem_rvalid,
  input  logic [thor_fetch_pkg::word_bits-1:0] mem_rdata,
  input  thor_fetch_pkg::src_t                 mem_rsrc
);

  logic [ccw-1:0] credits;       // free queue slots in main_mem
  logic           has_credit;
  logic           prio_dport;    // data port wins the next tie
  logic           gnt_fill;
  logic           gnt_dport;

  // ==========================================================
  // grant
  // ==========================================================
  assign has_credit  = (credits != '0);
  assign fill_ready  = has_credit && !(dport_req && prio_dport);  // not from own req
  assign dport_ready = has_credit && !(fill_req && !prio_dport);
  assign gnt_fill    = fill_req && fill_ready;
  assign gnt_dport   = dport_req && dport_ready;

  assign mem_req   = gnt_fill || gnt_dport;
  assign mem_we    = gnt_dport && dport_we;                       // fills only read
  assign mem_addr  = gnt_dport ? dport_addr : fill_addr;
  assign mem_wdata = dport_wdata;
  assign mem_src   = gnt_dport ? thor_fetch_pkg::src_dport : thor_fetch_pkg::src_ifill;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credits    <= ccw'(mem_queue_depth);
      prio_dport <= 1'b0;                     // fill port first after reset
    end else begin
      if (mem_req) begin
        prio_dport <= gnt_fill;               // the other side next time
      end
      case ({mem_req, mem_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;          // both or neither
      endcase
    end
  end

  // responses are never stalled
  assign fill_rvalid  = mem_rvalid && (mem_rsrc == thor_fetch_pkg::src_ifill);
  assign dport_rvalid = mem_rvalid && (mem_rsrc == thor_fetch_pkg::src_dport);
  assign fill_rdata   = mem_rdata;
  assign dport_rdata  = mem_rdata;

endmodule

`default_nettype wire

//--- rtl/thor_fetch_pkg.sv
// shared widths, source id type and cache line geometry for the fetch path
`default_nettype none

package thor_fetch_pkg;

  // ==========================================================
  // widths
  // ==========================================================
  localparam int abw       = 32;    // byte address width
  localparam int word_bits = 32;    // memory and fill word
  localparam int insn_bits = 128;   // fetch window

  // ==========================================================
  // line geometry
  // ==========================================================
  localparam int line_bytes     = 16;                      // bytes per cache line
  localparam int words_per_line = 4;                       // fill words per line
  localparam int off_bits       = $clog2(line_bytes);      // byte offset, pc[3:0]
  localparam int wsel_bits      = $clog2(words_per_line);  // word slot in a line
  localparam int line_bits      = line_bytes * 8;          // one line as a bit vector

  // which requester a memory request and its response belong to
  typedef enum logic {
    src_ifill = 1'b0,  // icache line fill
    src_dport = 1'b1   // external data port
  } src_t;

endpackage

`default_nettype wire

//--- rtl/thor_fetch_top.sv
// fetch top, icache data and control, data port, arbiter and backing memory
`timescale 1ns/1ps
`default_nettype none

module thor_fetch_top #(
  parameter int line_count      = 64,
  parameter int mem_words       = 1024,
  parameter int mem_queue_depth = 4
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 fetch_req,
  input  logic [thor_fetch_pkg::abw-1:0]       pc,
  output logic                                 fetch_valid,
  output logic [thor_fetch_pkg::insn_bits-1:0] insn,
  input  logic                                 dport_req,
  input  logic                                 dport_we,
  input  logic [thor_fetch_pkg::abw-1:0]       dport_addr,
  input  logic [thor_fetch_pkg::word_bits-1:0] dport_wdata,
  output logic                                 dport_ready,
  output logic                                 dport_rvalid,
  output logic [thor_fetch_pkg::word_bits-1:0] dport_rdata
);

  logic                                 fill_req;
  logic [thor_fetch_pkg::abw-1:0]       fill_addr;
  logic                                 fill_ready;
  logic                                 fill_rvalid;
  logic [thor_fetch_pkg::word_bits-1:0] fill_rdata;
  logic                                 wce;
  logic                                 wr;
  logic [thor_fetch_pkg::abw-1:0]       wa;
  logic [thor_fetch_pkg::word_bits-1:0] wd;
  logic                                 mem_req;
  logic                                 mem_we;
  logic [thor_fetch_pkg::abw-1:0]       mem_addr;
  logic [thor_fetch_pkg::word_bits-1:0] mem_wdata;
  thor_fetch_pkg::src_t                 mem_src;
  logic                                 mem_credit;
  logic                                 mem_rvalid;
  logic [thor_fetch_pkg::word_bits-1:0] mem_rdata;
  thor_fetch_pkg::src_t                 mem_rsrc;

  // single clock drives both cache memory ports
  icache_mem #(.line_count(line_count)) u_icache_mem (
    .wclk (clk), .wce (wce), .wr (wr), .wa (wa), .wd (wd),
    .rclk (clk), .pc (pc), .insn (insn)
  );

  icache_ctrl #(.line_count(line_count)) u_icache_ctrl (
    .clk (clk), .rst_n (rst_n), .fetch_req (fetch_req), .pc (pc),
    .fetch_valid (fetch_valid), .fill_req (fill_req), .fill_addr (fill_addr),
    .fill_ready (fill_ready), .fill_rvalid (fill_rvalid), .fill_rdata (fill_rdata),
    .wce (wce), .wr (wr), .wa (wa), .wd (wd)
  );

  mem_arbiter #(.mem_queue_depth(mem_queue_depth)) u_mem_arbiter (
    .clk (clk), .rst_n (rst_n),
    .fill_req (fill_req), .fill_addr (fill_addr), .fill_ready (fill_ready),
    .fill_rvalid (fill_rvalid), .fill_rdata (fill_rdata),
    .dport_req (dport_req), .dport_we (dport_we), .dport_addr (dport_addr),
    .dport_wdata (dport_wdata), .dport_ready (dport_ready),
    .dport_rvalid (dport_rvalid), .dport_rdata (dport_rdata),
    .mem_req (mem_req), .mem_we (mem_we), .mem_addr (mem_addr),
    .mem_wdata (mem_wdata), .mem_src (mem_src), .mem_credit (mem_credit),
    .mem_rvalid (mem_rvalid), .mem_rdata (mem_rdata), .mem_rsrc (mem_rsrc)
  );

  main_mem #(.mem_words(mem_words), .mem_queue_depth(mem_queue_depth)) u_main_mem (
    .clk (clk), .rst_n (rst_n),
    .mem_req (mem_req), .mem_we (mem_we), .mem_addr (mem_addr),
    .mem_wdata (mem_wdata), .mem_src (mem_src), .mem_credit (mem_credit),
    .mem_rvalid (mem_rvalid), .mem_rdata (mem_rdata), .mem_rsrc (mem_rsrc)
  );

endmodule

`default_nettype wire

//--- sources.f
rtl/thor_fetch_pkg.sv
rtl/icache_ram.sv
rtl/icache_mem.sv
rtl/icache_ctrl.sv
rtl/mem_arbiter.sv
rtl/main_mem.sv
rtl/thor_fetch_top.sv
tb/tb_thor_fetch.sv

//--- tb/tb_thor_fetch.sv
// testbench for thor_fetch_top, lfsr stimulus, byte model of main memory
// concurrent assertions on fetch window, hit timing and data port reads
`timescale 1ns/1ps
`default_nettype none

module tb_thor_fetch;

  localparam int n_fills     = 12;   // line fills over the whole run
  localparam int n_access    = 230;  // data port accesses plus fetches
  localparam int fill_lat    = 48;   // worst fill with the queue full of data port traffic
  localparam int cycle_limit = (n_fills + n_access) * fill_lat;

  logic         clk;
  logic         rst_n;
  logic         fetch_req;
  logic [31:0]  pc;
  logic         fetch_valid;
  logic [127:0] insn;
  logic         dport_req;
  logic         dport_we;
  logic [31:0]  dport_addr;
  logic [31:0]  dport_wdata;
  logic         dport_ready;
  logic         dport_rvalid;
  logic [31:0]  dport_rdata;

  logic [15:0]  lfsr;
  logic [7:0]   model [1024];        // main memory by byte
  logic [31:0]  exp_fifo [32];       // read data owed to the data port
  logic [4:0]   rd_head;
  logic [4:0]   rd_tail;
  logic [31:0]  exp_rdata;
  logic [127:0] exp_insn;
  logic         quiet;               // no traffic so outputs must idle
  logic         hit_exp;             // fetch must hit
  logic         miss_exp;            // fetch must miss
  int           cycles;

  thor_fetch_top #(.line_count(16), .mem_words(256), .mem_queue_depth(4)) UUT (
    .clk (clk), .rst_n (rst_n), .fetch_req (fetch_req), .pc (pc),
    .fetch_valid (fetch_valid), .insn (insn),
    .dport_req (dport_req), .dport_we (dport_we), .dport_addr (dport_addr),
    .dport_wdata (dport_wdata), .dport_ready (dport_ready),
    .dport_rvalid (dport_rvalid), .dport_rdata (dport_rdata)
  );

  always #10 clk = ~clk;             // 20 ns period

  // ============================================================
  // helpers
  // ============================================================
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11
  endfunction

  function automatic logic [31:0] word_at(input logic [31:0] addr);
    logic [9:0] a;
    a = {addr[9:2], 2'b00};
    return {model[a + 10'd3], model[a + 10'd2], model[a + 10'd1], model[a]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};     // one step per bit
    end
  endtask

  task automatic halt_run();
    $display("test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic mismatch(input string sig, input logic [127:0] exp, input logic [127:0] act);
    $display("[FAIL] %0t %s expected %h got %h", $time, sig, exp, act);
    halt_run();
  endtask

  task automatic failure(input string what);
    $display("%0t %s", $time, what);
    halt_run();
  endtask

  task automatic step();
    @(posedge clk);
    #2;                              // drive and look after the edge settles
  endtask

  // request stays up so back to back calls form a stream
  task automatic issue_access(input logic we, input logic [31:0] addr, input logic [31:0] data);
    logic taken;
    dport_req   = 1'b1;
    dport_we    = we;
    dport_addr  = addr;
    dport_wdata = data;
    taken       = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = dport_ready;           // stable until the edge
      step();
    end
  endtask

  task automatic release_port();
    dport_req = 1'b0;
    dport_we  = 1'b0;
  endtask

  task automatic wait_reads_done();
    while (rd_head != rd_tail) step();
  endtask

  task automatic read_stream(input int n);
    logic [31:0] w;
    for (int i = 0; i < n; i++) begin
      take_bits(6, w);               // word 0..63 of the written region
      issue_access(1'b0, {w[29:0], 2'b00}, 32'h0);
    end
    release_port();
  endtask

  task automatic run_fetch(input logic [31:0] addr, input logic hit, input logic miss);
    pc        = addr;
    fetch_req = 1'b1;
    hit_exp   = hit;
    miss_exp  = miss;
    step();
    while (!fetch_valid) step();
    fetch_req = 1'b0;
    hit_exp   = 1'b0;
    miss_exp  = 1'b0;
    step();                          // pc held over the checking edge
  endtask

  // ============================================================
  // reference model
  // ============================================================
  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 1024; i++) model[i] <= 8'h00;   // memory clears on reset
      rd_head <= '0;
      rd_tail <= '0;
    end else begin
      if (dport_req && dport_ready && dport_we) begin
        for (int b = 0; b < 4; b++) model[{dport_addr[9:2], 2'(b)}] <= dport_wdata[8*b +: 8];
      end
      if (dport_req && dport_ready && !dport_we) begin
        exp_fifo[rd_tail] <= word_at(dport_addr);         // in request order
        rd_tail           <= rd_tail + 1'b1;
      end
      if (dport_rvalid) rd_head <= rd_head + 1'b1;
    end
  end

  assign exp_rdata = exp_fifo[rd_head];

  always_comb begin
    for (int k = 0; k < 16; k++) begin
      exp_insn[8*k +: 8] = model[10'(pc + 32'(k))];       // byte k is memory byte pc+k
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == cycle_limit) failure("run did not finish within the cycle limit");
  end

  // ============================================================
  // checks
  // ============================================================
  a_idle_fetch: assert property (@(posedge clk) disable iff (!rst_n) quiet |-> !fetch_valid)
    else mismatch("fetch_valid", 128'(0), 128'($sampled(fetch_valid)));
  a_idle_rvalid: assert property (@(posedge clk) disable iff (!rst_n) quiet |-> !dport_rvalid)
    else mismatch("dport_rvalid", 128'(0), 128'($sampled(dport_rvalid)));
  a_idle_ready: assert property (@(posedge clk) disable iff (!rst_n) quiet |-> dport_ready)
    else mismatch("dport_ready", 128'(1), 128'($sampled(dport_ready)));
  a_insn: assert property (@(posedge clk) disable iff (!rst_n) fetch_valid |-> insn == exp_insn)
    else mismatch("insn", $sampled(exp_insn), $sampled(insn));
  a_hit_timing: assert property (@(posedge clk) disable iff (!rst_n)
                                 $rose(fetch_req) && hit_exp |=> fetch_valid)
    else failure("fetch_valid missing one cycle after a fetch that should hit");
  a_miss: assert property (@(posedge clk) disable iff (!rst_n)
                           $rose(fetch_req) && miss_exp |=> !fetch_valid)
    else failure("fetch answered in one cycle although its line was not in the cache");
  a_valid_src: assert property (@(posedge clk) disable iff (!rst_n)
                                fetch_valid |-> $past(fetch_req))
    else failure("fetch_valid raised without a fetch request");
  a_rd_owed: assert property (@(posedge clk) disable iff (!rst_n)
                              dport_rvalid |-> rd_head != rd_tail)
    else failure("data port read response with no read outstanding");
  a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
                            dport_rvalid |-> dport_rdata == exp_rdata)
    else mismatch("dport_rdata", 128'($sampled(exp_rdata)), 128'($sampled(dport_rdata)));

  // ============================================================
  // stimulus
  // ============================================================
  initial begin
    logic [31:0] v;
    logic [31:0] base;
    clk         = 1'b0;
    rst_n       = 1'b0;
    fetch_req   = 1'b0;
    pc          = '0;
    dport_req   = 1'b0;
    dport_we    = 1'b0;
    dport_addr  = '0;
    dport_wdata = '0;
    quiet       = 1'b0;
    hit_exp     = 1'b0;
    miss_exp    = 1'b0;
    cycles      = 0;
    lfsr        = 16'd48;            // seed
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;

    quiet = 1'b1;                    // idle outputs after reset
    repeat (6) step();
    quiet = 1'b0;

    for (int i = 0; i < 80; i++) begin       // fill bytes 0x000..0x13f
      take_bits(32, v);
      issue_access(1'b1, 32'(i * 4), v);
    end
    for (int i = 0; i < 80; i++) issue_access(1'b0, 32'(i * 4), 32'h0);  // read back
    release_port();
    wait_reads_done();

    for (int off = 0; off < 16; off++) begin // every offset over lines 4 and 5
      run_fetch(32'h40 + 32'(off), off != 0, off == 0);
      run_fetch(32'h40 + 32'(off), 1'b1, 1'b0);
    end
    take_bits(1, v);
    base = v[0] ? 32'h70 : 32'h60;           // line 6 or 7 which stays clear of line 10
    for (int j = 0; j < 8; j++) begin
      take_bits(4, v);
      run_fetch(base + v, 1'b0, 1'b0);
      run_fetch(base + v, 1'b1, 1'b0);
    end

    take_bits(4, v);                         // miss on line 10 under data port load
    fork
      run_fetch(32'hA0 + v, 1'b0, 1'b1);
      read_stream(16);
    join
    wait_reads_done();

    take_bits(4, v);                         // last index with the window wrapping to index 0
    if (v == 0) v = 32'd9;
    run_fetch(32'hF0 + v, 1'b0, 1'b1);
    take_bits(4, v);
    run_fetch(v, 1'b0, 1'b1);                // index 0 now holds the line at 0x100

    repeat (4) step();
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire
